// ==== testbench/rename_testdata.txt ====
# name valid we rs1_0 rs1_1 rs2_0 rs2_1 rd_0 rd_1 stall commit_valid commit_prd_0 commit_prd_1 accept stall_after
#   then expected out_valid out_wen prs1_0 prs1_1 prs2_0 prs2_1 prd_0 prd_1 old_prd_0 old_prd_1 rob_0 rob_1
t1_indep 3 3 1 4 2 5 3 6 0 0 0 0 1 0 3 3 1 4 2 5 32 33 3 6 0 1
t1_reread 3 3 3 6 6 3 7 8 0 0 0 0 1 0 3 3 32 33 33 32 34 35 7 8 2 3
t2_raw 3 3 1 9 2 3 9 10 0 0 0 0 1 1 3 3 1 36 2 32 36 37 9 10 4 5
t6_stall_hold 3 3 0 11 0 0 11 11 1 0 0 0 0 1 3 3 1 36 2 32 36 37 9 10 4 5
t3_waw 3 3 0 11 0 0 11 11 0 0 0 0 1 0 3 3 0 38 0 0 38 39 11 38 6 7
t4_no_alloc 3 1 11 10 9 11 0 12 0 0 0 0 1 0 3 0 39 37 36 39 0 0 0 0 8 9
t4_single 1 0 3 0 6 0 5 0 0 0 0 0 1 0 1 0 32 0 33 0 0 0 0 0 10 0
drain_0 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 13 40 14 14 40 41 13 14 11 12
drain_1 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 40 42 41 41 42 43 40 41 13 14
t6_wrap 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 42 44 43 43 44 45 42 43 15 16
drain_3 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 44 46 45 45 46 47 44 45 17 18
drain_4 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 46 48 47 47 48 49 46 47 19 20
drain_5 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 48 50 49 49 50 51 48 49 21 22
drain_6 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 50 52 51 51 52 53 50 51 23 24
drain_7 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 52 54 53 53 54 55 52 53 25 26
drain_8 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 54 56 55 55 56 57 54 55 27 28
drain_9 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 56 58 57 57 58 59 56 57 29 30
t6_wrap_back 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 58 60 59 59 60 61 58 59 31 0
drain_11 3 3 13 13 14 14 13 14 0 0 0 0 1 0 3 3 60 62 61 61 62 63 60 61 1 2
t5_exhausted 3 3 13 13 14 14 15 16 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
t5_refill 3 3 13 13 14 14 15 16 0 3 11 38 1 0 3 3 62 62 63 63 11 38 15 16 3 4

// ==== tb.f ====
+incdir+design
design/rename_pkg.sv
design/rename_table.sv
design/free_list.sv
design/rename_stage.sv
design/rename_top.sv
testbench/tb_clock.sv
testbench/tb_rename.sv

// ==== Makefile ====
SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_rename: tb.f $(SOURCES)
	verilator --binary --timing --top-module tb_rename -f tb.f -o Vtb_rename

run: obj_dir/Vtb_rename testbench/rename_testdata.txt
	./obj_dir/Vtb_rename > sim.log; cat sim.log; grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_rename.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module tb_rename;

    localparam int TIMEOUT = 50;

    logic                                    clk;
    logic                                    reset;
    logic [`FETCH_WIDTH-1:0]                 in_valid;
    logic [`FETCH_WIDTH-1:0]                 in_we;
    rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rs1;
    rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rs2;
    rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rd;
    logic                                    in_ready;
    logic [`FETCH_WIDTH-1:0]                 out_valid;
    logic [`FETCH_WIDTH-1:0]                 out_wen;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prs1;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prs2;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prd;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_old_prd;
    rename_pkg::rob_idx_t [`FETCH_WIDTH-1:0] out_rob_idx;
    logic                                    out_stall;
    logic [`FETCH_WIDTH-1:0]                 commit_valid;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    commit_prd;

    // Fields of one data line, in file order after the test name.
    int    f [26];
    string line;
    string name;
    int    fd;
    int    n;
    int    tests;
    int    passed;
    int    failed;
    int    errors;
    int    errors_before;
    bit    timed_out;

    tb_clock i_tb_clock (
        .clk (clk)
    );

    rename_top i_rename_top (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_we        (in_we),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_rd        (in_rd),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_wen      (out_wen),
        .out_prs1     (out_prs1),
        .out_prs2     (out_prs2),
        .out_prd      (out_prd),
        .out_old_prd  (out_old_prd),
        .out_rob_idx  (out_rob_idx),
        .out_stall    (out_stall),
        .commit_valid (commit_valid),
        .commit_prd   (commit_prd)
    );

    task automatic check_value(input string test, input string field,
                               input int expected, input int actual);
        if (expected !== actual) begin
            errors++;
            $display("error: test %s %s expected %0d actual %0d",
                     test, field, expected, actual);
        end
    endtask

    // Data fields are only meaningful for slots that the expected flags mark.
    task automatic check_outputs(input string test);
        check_value(test, "out_valid", f[14], int'(out_valid));
        check_value(test, "out_wen", f[15], int'(out_wen));
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (((f[14] >> i) & 1) != 0) begin
                check_value(test, $sformatf("out_prs1[%0d]", i), f[16 + i], int'(out_prs1[i]));
                check_value(test, $sformatf("out_prs2[%0d]", i), f[18 + i], int'(out_prs2[i]));
                check_value(test, $sformatf("out_rob_idx[%0d]", i), f[24 + i],
                            int'(out_rob_idx[i]));
            end
            if (((f[15] >> i) & 1) != 0) begin
                check_value(test, $sformatf("out_prd[%0d]", i), f[20 + i], int'(out_prd[i]));
                check_value(test, $sformatf("out_old_prd[%0d]", i), f[22 + i],
                            int'(out_old_prd[i]));
            end
        end
    endtask

    task automatic drive_group();
        in_valid     <= f[0][`FETCH_WIDTH-1:0];
        in_we        <= f[1][`FETCH_WIDTH-1:0];
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            in_rs1[i]     <= rename_pkg::areg_t'(f[2 + i]);
            in_rs2[i]     <= rename_pkg::areg_t'(f[4 + i]);
            in_rd[i]      <= rename_pkg::areg_t'(f[6 + i]);
            commit_prd[i] <= rename_pkg::preg_t'(f[10 + i]);
        end
        out_stall    <= f[8][0];
        commit_valid <= f[9][`FETCH_WIDTH-1:0];
    endtask

    // Commits are held for one edge only, so each release happens once.
    task automatic wait_ready(input string test);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!in_ready && cycles < TIMEOUT) begin
            @(posedge clk);
            commit_valid <= '0;
            cycles++;
            @(negedge clk);
        end
        if (!in_ready) begin
            timed_out = 1'b1;
            $display("timeout: in_ready never rose in test %s", test);
        end
    endtask

    task automatic wait_out_valid(input string test, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (out_valid == '0 && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (out_valid == '0) begin
            timed_out = 1'b1;
            $display("timeout: no output group appeared in test %s", test);
        end
    endtask

    task automatic run_accepted(input string test);
        int late;
        wait_ready(test);
        if (!timed_out) begin
            @(posedge clk);
            in_valid     <= '0;
            commit_valid <= '0;
            out_stall    <= f[13][0];
            wait_out_valid(test, late);
            if (!timed_out) begin
                // The group shows up on the edge right after it is accepted.
                check_value(test, "output delay in cycles", 0, late);
                check_outputs(test);
            end
        end
    endtask

    // The group stays driven, since the source must hold it until accepted.
    task automatic run_refused(input string test);
        repeat (3) begin
            @(negedge clk);
            check_value(test, "in_ready", 0, int'(in_ready));
            @(posedge clk);
            commit_valid <= '0;
        end
        @(negedge clk);
        check_outputs(test);
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = '0;
        in_we        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_rd        = '0;
        out_stall    = 1'b0;
        commit_valid = '0;
        commit_prd   = '0;
        tests        = 0;
        passed       = 0;
        failed       = 0;
        errors       = 0;
        timed_out    = 1'b0;

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("testbench/rename_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/rename_testdata.txt");
        end

        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                f[20], f[21], f[22], f[23], f[24], f[25]);
            tests++;
            if (n != 27) begin
                failed++;
                $display("test line %0d could not be parsed: %s", tests, line);
                continue;
            end
            errors_before = errors;
            @(posedge clk);
            drive_group();
            if (f[12] != 0) begin
                run_accepted(name);
            end else begin
                run_refused(name);
            end
            if (errors == errors_before && !timed_out) begin
                passed++;
                $display("test %s: pass", name);
            end else begin
                failed++;
                $display("test %s: fail with %0d mismatches", name, errors - errors_before);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests, passed, failed, errors);
        if (fd != 0 && !timed_out && failed == 0 && errors == 0 && tests > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period.
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

// ==== design/rename_top.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [`FETCH_WIDTH-1:0]                 in_valid,
    input  logic [`FETCH_WIDTH-1:0]                 in_we,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rs1,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rs2,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rd,
    output logic                                    in_ready,
    output logic [`FETCH_WIDTH-1:0]                 out_valid,
    output logic [`FETCH_WIDTH-1:0]                 out_wen,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prs1,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prs2,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prd,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_old_prd,
    output rename_pkg::rob_idx_t [`FETCH_WIDTH-1:0] out_rob_idx,
    input  logic                                    out_stall,
    input  logic [`FETCH_WIDTH-1:0]                 commit_valid,
    input  rename_pkg::preg_t [`FETCH_WIDTH-1:0]    commit_prd
);

    rename_pkg::areg_t [`FETCH_WIDTH-1:0] rd_rs1;
    rename_pkg::areg_t [`FETCH_WIDTH-1:0] rd_rs2;
    rename_pkg::areg_t [`FETCH_WIDTH-1:0] rd_rd;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0] map_rs1;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0] map_rs2;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0] map_rd;
    logic [`FETCH_WIDTH-1:0]              tbl_we;
    rename_pkg::areg_t [`FETCH_WIDTH-1:0] tbl_vrd;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0] tbl_prd;
    rename_pkg::group_cnt_t               alloc_num;
    logic                                 alloc_take;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0] alloc_prd;
    logic                                 alloc_short;

    rename_stage i_rename_stage (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_we       (in_we),
        .in_rs1      (in_rs1),
        .in_rs2      (in_rs2),
        .in_rd       (in_rd),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_wen     (out_wen),
        .out_prs1    (out_prs1),
        .out_prs2    (out_prs2),
        .out_prd     (out_prd),
        .out_old_prd (out_old_prd),
        .out_rob_idx (out_rob_idx),
        .out_stall   (out_stall),
        .rd_rs1      (rd_rs1),
        .rd_rs2      (rd_rs2),
        .rd_rd       (rd_rd),
        .map_rs1     (map_rs1),
        .map_rs2     (map_rs2),
        .map_rd      (map_rd),
        .tbl_we      (tbl_we),
        .tbl_vrd     (tbl_vrd),
        .tbl_prd     (tbl_prd),
        .alloc_num   (alloc_num),
        .alloc_take  (alloc_take),
        .alloc_prd   (alloc_prd),
        .alloc_short (alloc_short)
    );

    rename_table i_rename_table (
        .clk     (clk),
        .reset   (reset),
        .rd_rs1  (rd_rs1),
        .rd_rs2  (rd_rs2),
        .rd_rd   (rd_rd),
        .map_rs1 (map_rs1),
        .map_rs2 (map_rs2),
        .map_rd  (map_rd),
        .tbl_we  (tbl_we),
        .tbl_vrd (tbl_vrd),
        .tbl_prd (tbl_prd)
    );

    free_list i_free_list (
        .clk          (clk),
        .reset        (reset),
        .alloc_num    (alloc_num),
        .alloc_take   (alloc_take),
        .alloc_prd    (alloc_prd),
        .alloc_short  (alloc_short),
        .commit_valid (commit_valid),
        .commit_prd   (commit_prd)
    );

endmodule

// ==== design/rename_stage.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_stage (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [`FETCH_WIDTH-1:0]                 in_valid,
    input  logic [`FETCH_WIDTH-1:0]                 in_we,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rs1,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rs2,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0]    in_rd,
    output logic                                    in_ready,
    output logic [`FETCH_WIDTH-1:0]                 out_valid,
    output logic [`FETCH_WIDTH-1:0]                 out_wen,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prs1,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prs2,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_prd,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    out_old_prd,
    output rename_pkg::rob_idx_t [`FETCH_WIDTH-1:0] out_rob_idx,
    input  logic                                    out_stall,
    output rename_pkg::areg_t [`FETCH_WIDTH-1:0]    rd_rs1,
    output rename_pkg::areg_t [`FETCH_WIDTH-1:0]    rd_rs2,
    output rename_pkg::areg_t [`FETCH_WIDTH-1:0]    rd_rd,
    input  rename_pkg::preg_t [`FETCH_WIDTH-1:0]    map_rs1,
    input  rename_pkg::preg_t [`FETCH_WIDTH-1:0]    map_rs2,
    input  rename_pkg::preg_t [`FETCH_WIDTH-1:0]    map_rd,
    output logic [`FETCH_WIDTH-1:0]                 tbl_we,
    output rename_pkg::areg_t [`FETCH_WIDTH-1:0]    tbl_vrd,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0]    tbl_prd,
    output rename_pkg::group_cnt_t                  alloc_num,
    output logic                                    alloc_take,
    input  rename_pkg::preg_t [`FETCH_WIDTH-1:0]    alloc_prd,
    input  logic                                    alloc_short
);

    logic [`FETCH_WIDTH-1:0]                 wr;
    logic [`FETCH_WIDTH-1:0]                 overridden;
    rename_pkg::group_cnt_t [`FETCH_WIDTH-1:0] alloc_slot;
    rename_pkg::group_cnt_t [`FETCH_WIDTH-1:0] rob_slot;
    rename_pkg::group_cnt_t                  valid_num;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    new_prd;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    prs1;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    prs2;
    rename_pkg::preg_t [`FETCH_WIDTH-1:0]    old_prd;
    rename_pkg::rob_idx_t                    rob_ptr;
    logic                                    stall;
    logic                                    accept;

    assign stall      = alloc_short | out_stall;
    assign in_ready   = ~stall;
    assign accept     = (|in_valid) & in_ready;
    assign alloc_take = accept;

    assign rd_rs1 = in_rs1;
    assign rd_rs2 = in_rs2;
    assign rd_rd  = in_rd;

    // Writers and valid slots are numbered in slot order by running counts.
    always_comb begin
        alloc_num = '0;
        valid_num = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            wr[i]         = in_valid[i] & in_we[i] & (in_rd[i] != '0);
            alloc_slot[i] = alloc_num;
            rob_slot[i]   = valid_num;
            alloc_num     = alloc_num + rename_pkg::group_cnt_t'(wr[i]);
            valid_num     = valid_num + rename_pkg::group_cnt_t'(in_valid[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            new_prd[i] = wr[i] ? alloc_prd[alloc_slot[i]] : '0;
        end
    end

    // Older writers in the group shadow the table. Scanning from slot 0 up
    // leaves the nearest older match in place.
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            prs1[i]       = map_rs1[i];
            prs2[i]       = map_rs2[i];
            old_prd[i]    = wr[i] ? map_rd[i] : '0;
            overridden[i] = 1'b0;
            for (int j = 0; j < `FETCH_WIDTH; j++) begin
                if (j < i) begin
                    if (wr[j] && in_rd[j] == in_rs1[i]) begin
                        prs1[i] = new_prd[j];
                    end
                    if (wr[j] && in_rd[j] == in_rs2[i]) begin
                        prs2[i] = new_prd[j];
                    end
                    if (wr[j] && wr[i] && in_rd[j] == in_rd[i]) begin
                        old_prd[i] = new_prd[j];
                    end
                end else if (j > i) begin
                    // A younger writer of the same rd owns the final mapping.
                    if (wr[j] && in_rd[j] == in_rd[i]) begin
                        overridden[i] = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            tbl_we[i]  = wr[i] & ~overridden[i] & accept;
            tbl_vrd[i] = in_rd[i];
            tbl_prd[i] = new_prd[i];
        end
    end

    // The wrap bit sits on top of the index, so a plain add flips it past 15.
    always_ff @(posedge clk) begin
        if (reset) begin
            rob_ptr <= '0;
        end else if (accept) begin
            rob_ptr <= rob_ptr + rename_pkg::rob_idx_t'(valid_num);
        end
    end

    // A free cycle with nothing accepted sends a bubble downstream.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
            out_wen   <= '0;
        end else if (!out_stall) begin
            out_valid <= accept ? in_valid : '0;
            out_wen   <= accept ? wr : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                out_prs1[i]    <= prs1[i];
                out_prs2[i]    <= prs2[i];
                out_prd[i]     <= new_prd[i];
                out_old_prd[i] <= old_prd[i];
                out_rob_idx[i] <= rob_ptr + rename_pkg::rob_idx_t'(rob_slot[i]);
            end
        end
    end

endmodule

// ==== design/free_list.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module free_list (
    input  logic                                 clk,
    input  logic                                 reset,
    input  rename_pkg::group_cnt_t               alloc_num,
    input  logic                                 alloc_take,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0] alloc_prd,
    output logic                                 alloc_short,
    input  logic [`FETCH_WIDTH-1:0]              commit_valid,
    input  rename_pkg::preg_t [`FETCH_WIDTH-1:0] commit_prd
);

    localparam int PTR_W = $clog2(`PHYS_REGS);
    localparam int CNT_W = $clog2(`PHYS_REGS) + 1;

    rename_pkg::preg_t fifo [`PHYS_REGS];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic [PTR_W-1:0] push_ptr [`FETCH_WIDTH];
    logic [CNT_W-1:0] push_num;
    logic [CNT_W-1:0] pop_num;

    // The first alloc_num entries at the head are offered without popping.
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            alloc_prd[i] = fifo[head + PTR_W'(i)];
        end
    end

    assign alloc_short = count < CNT_W'(alloc_num);
    assign pop_num     = alloc_take ? CNT_W'(alloc_num) : '0;

    // Commits are packed at the tail in slot order, skipping empty slots.
    always_comb begin
        push_num = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            push_ptr[i] = tail + PTR_W'(push_num);
            push_num    = push_num + CNT_W'(commit_valid[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Registers above the architectural range start free, lowest first.
            // Entries past the count wrap around and carry no meaning.
            for (int i = 0; i < `PHYS_REGS; i++) begin
                fifo[i] <= rename_pkg::preg_t'(`ARCH_REGS + i);
            end
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (commit_valid[i]) begin
                    fifo[push_ptr[i]] <= commit_prd[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= PTR_W'(`PHYS_REGS - `ARCH_REGS);
            count <= CNT_W'(`PHYS_REGS - `ARCH_REGS);
        end else begin
            head  <= head + PTR_W'(pop_num);
            tail  <= tail + PTR_W'(push_num);
            count <= count - pop_num + push_num;
        end
    end

endmodule

// ==== design/rename_table.sv ====
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_table (
    input  logic                                 clk,
    input  logic                                 reset,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0] rd_rs1,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0] rd_rs2,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0] rd_rd,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0] map_rs1,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0] map_rs2,
    output rename_pkg::preg_t [`FETCH_WIDTH-1:0] map_rd,
    input  logic [`FETCH_WIDTH-1:0]              tbl_we,
    input  rename_pkg::areg_t [`FETCH_WIDTH-1:0] tbl_vrd,
    input  rename_pkg::preg_t [`FETCH_WIDTH-1:0] tbl_prd
);

    rename_pkg::preg_t map [`ARCH_REGS];

    // Reads see the table as it stood before this cycle's writes.
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            map_rs1[i] = map[rd_rs1[i]];
            map_rs2[i] = map[rd_rs2[i]];
            map_rd[i]  = map[rd_rd[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map: each architectural register starts in its own slot.
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= rename_pkg::preg_t'(i);
            end
        end else begin
            // Later slots are younger, so the last write in the loop wins.
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (tbl_we[i]) begin
                    map[tbl_vrd[i]] <= tbl_prd[i];
                end
            end
        end
    end

endmodule

// ==== design/rename_pkg.sv ====
`include "rename_consts.svh"

package rename_pkg;

    // Architectural register number.
    typedef logic [$clog2(`ARCH_REGS)-1:0] areg_t;

    // Physical register number.
    typedef logic [$clog2(`PHYS_REGS)-1:0] preg_t;

    // ROB index with the wrap bit as the top bit.
    typedef logic [$clog2(`ROB_DEPTH):0] rob_idx_t;

    // Number of instructions in a group, 0 up to FETCH_WIDTH.
    typedef logic [$clog2(`FETCH_WIDTH+1)-1:0] group_cnt_t;

endpackage

// ==== design/rename_consts.svh ====
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Instructions renamed together in one group.
`define FETCH_WIDTH 2

// Architectural register file size; register 0 is never renamed.
`define ARCH_REGS 32

// Physical register file size. The upper part starts out in the free list.
`define PHYS_REGS 64

// Reorder buffer entries; a power of two so the wrap bit falls out of the add.
`define ROB_DEPTH 16

`endif
